/* Makefile */
# Verilator build and run of the I/Q analyzer testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module iq_analyzer_tb -Mdir obj_dir -o iq_analyzer_sim

run: compile
	@out=$$(./obj_dir/iq_analyzer_sim 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

/* compile.f */
+incdir+include
logic/iq_analyzer_pkg.sv
logic/line_classifier.sv
logic/class_counter.sv
logic/run_controller.sv
logic/channel_mux.sv
logic/iq_analyzer.sv
verif/iq_analyzer_tb.sv

/* include/iq_analyzer_settings.svh */
/* widths shared by the analyzer package and RTL
   the classifier datapath is built for a latency of exactly 3 */
`ifndef IQ_ANALYZER_SETTINGS_SVH
`define IQ_ANALYZER_SETTINGS_SVH

// signed I/Q samples and line parameters
`define IQ_SAMPLE_W 32

// point count and per-class totals, wrap silently past 65535
`define IQ_COUNT_W 16

// output channel word, at least 2*IQ_SAMPLE_W wide for dump mode
`define IQ_CHANNEL_W 128

// cycles from an accepted sample to its class strobe
`define IQ_CLASS_LATENCY 3

`endif

/* logic/channel_mux.sv */
/* registered output stage, one word per valid strobe
   report word sits in the low 80 bits, upper bits zero */
`timescale 1ns/10ps

module channel_mux import iq_analyzer_pkg::*; (
    input  logic          clk100,
    input  logic          reset,
    input  analyze_mode_t i_mode,
    input  logic          i_stream,       // classify mode, per-sample codes
    input  logic          i_data_valid,
    input  sample_t       i_i_val,
    input  sample_t       i_q_val,
    input  logic          i_class_valid,
    input  class_t        i_class,
    input  logic          i_report,       // counts below are a finished run
    input  count_t        i_points,
    input  count_t        i_excited,
    input  count_t        i_ground,
    input  count_t        i_line,
    output logic          o_valid,
    output channel_t      o_channels
);

    channel_t dump_word;
    channel_t stream_word;
    channel_t report_word;

    // zero-extended into the channel width
    assign dump_word   = channel_t'({i_i_val, i_q_val});     // I above Q
    assign stream_word = channel_t'(i_class);                 // code in bits 1:0
    assign report_word = channel_t'({REPORT_DONE, i_points,
                                     i_excited, i_ground, i_line});

    always_ff @(posedge clk100) begin
        if (reset) begin
            o_valid    <= 1'b0;
            o_channels <= '0;
        end else begin
            o_valid <= 1'b0;  // single-cycle strobe, word holds between
            case (i_mode)
                MODE_DUMP: begin
                    if (i_data_valid) begin
                        o_valid    <= 1'b1;
                        o_channels <= dump_word;
                    end
                end
                MODE_CLASSIFY: begin
                    if (i_stream) begin
                        if (i_class_valid) begin
                            o_valid    <= 1'b1;
                            o_channels <= stream_word;
                        end
                    end else if (i_report) begin
                        o_valid    <= 1'b1;
                        o_channels <= report_word;
                    end
                end
                default: ;  // reserved modes stay silent
            endcase
        end
    end

endmodule

/* logic/class_counter.sv */
/* running totals of classified points, cleared by i_clear
   a strobe in the clear cycle starts the new run at one */
`timescale 1ns/10ps

module class_counter import iq_analyzer_pkg::*; (
    input  logic   clk100,
    input  logic   reset,
    input  logic   i_clear,        // restart the run at the next edge
    input  logic   i_class_valid,
    input  class_t i_class,
    output count_t o_points,
    output count_t o_excited,
    output count_t o_ground,
    output count_t o_line
);

    logic hit_excited;
    logic hit_ground;
    logic hit_line;

    assign hit_excited = i_class_valid && (i_class == CLASS_EXCITED);
    assign hit_ground  = i_class_valid && (i_class == CLASS_GROUND);
    assign hit_line    = i_class_valid && (i_class == CLASS_LINE);

    always_ff @(posedge clk100) begin
        if (reset) begin
            o_points  <= '0;
            o_excited <= '0;
            o_ground  <= '0;
            o_line    <= '0;
        end else if (i_clear) begin
            // new run, current strobe (if any) is its first point
            o_points  <= count_t'(i_class_valid);
            o_excited <= count_t'(hit_excited);
            o_ground  <= count_t'(hit_ground);
            o_line    <= count_t'(hit_line);
        end else begin
            o_points  <= o_points + count_t'(i_class_valid);
            o_excited <= o_excited + count_t'(hit_excited);
            o_ground  <= o_ground + count_t'(hit_ground);
            o_line    <= o_line + count_t'(hit_line);
        end
    end

    // class totals always add up to the point count
    a_totals_match: assert property (@(posedge clk100) disable iff (reset)
        o_points == count_t'(o_excited + o_ground + o_line));

endmodule

/* logic/iq_analyzer.sv */
/* I/Q readout analyzer with data dump and linear classification modes
   configuration inputs may only change while reset is held */
`timescale 1ns/10ps

module iq_analyzer import iq_analyzer_pkg::*; (
    input  logic          clk100,
    input  logic          reset,
    input  analyze_mode_t i_mode,
    input  logic          i_stream,      // classify: 1 stream codes, 0 count reports
    input  count_t        i_num_points,  // classifications per report
    input  logic          i_data_valid,
    input  sample_t       i_i_val,
    input  sample_t       i_q_val,
    input  sample_t       i_i_line,
    input  sample_t       i_q_line,
    input  sample_t       i_i_perp,
    input  sample_t       i_q_perp,
    output logic          o_valid,
    output channel_t      o_channels
);

    logic   class_valid;
    class_t class_code;
    count_t points;
    count_t excited;
    count_t ground;
    count_t line_cnt;
    logic   run_clear;
    logic   run_report;

    line_classifier u_line_classifier (
        .clk100        (clk100),
        .reset         (reset),
        .i_data_valid  (i_data_valid),
        .i_i_val       (i_i_val),
        .i_q_val       (i_q_val),
        .i_i_line      (i_i_line),
        .i_q_line      (i_q_line),
        .i_i_perp      (i_i_perp),
        .i_q_perp      (i_q_perp),
        .o_class_valid (class_valid),
        .o_class       (class_code)
    );

    class_counter u_class_counter (
        .clk100        (clk100),
        .reset         (reset),
        .i_clear       (run_clear),
        .i_class_valid (class_valid),
        .i_class       (class_code),
        .o_points      (points),
        .o_excited     (excited),
        .o_ground      (ground),
        .o_line        (line_cnt)
    );

    run_controller u_run_controller (
        .clk100        (clk100),
        .reset         (reset),
        .i_mode        (i_mode),
        .i_stream      (i_stream),
        .i_num_points  (i_num_points),
        .i_points      (points),
        .o_clear       (run_clear),
        .o_report      (run_report)
    );

    channel_mux u_channel_mux (
        .clk100        (clk100),
        .reset         (reset),
        .i_mode        (i_mode),
        .i_stream      (i_stream),
        .i_data_valid  (i_data_valid),
        .i_i_val       (i_i_val),
        .i_q_val       (i_q_val),
        .i_class_valid (class_valid),
        .i_class       (class_code),
        .i_report      (run_report),
        .i_points      (points),
        .i_excited     (excited),
        .i_ground      (ground),
        .i_line        (line_cnt),
        .o_valid       (o_valid),
        .o_channels    (o_channels)
    );

endmodule

/* logic/iq_analyzer_pkg.sv */
/* types shared by the analyzer blocks
   modes 2 and 3 are reserved and give no output */
`include "iq_analyzer_settings.svh"

package iq_analyzer_pkg;

    typedef logic signed [`IQ_SAMPLE_W-1:0] sample_t;   // I, Q and line params
    typedef logic        [`IQ_COUNT_W-1:0]  count_t;    // point / class totals
    typedef logic        [`IQ_CHANNEL_W-1:0] channel_t; // output word

    // analyzer mode, 2 and 3 reserved (3 was the histogram)
    typedef enum logic [1:0] {
        MODE_DUMP     = 2'd0,  // re-emit each sample
        MODE_CLASSIFY = 2'd1   // linear classification
    } analyze_mode_t;

    // class codes as seen on the channels
    typedef enum logic [1:0] {
        CLASS_ERROR   = 2'd0,  // kept for the encoding, never produced
        CLASS_GROUND  = 2'd1,
        CLASS_EXCITED = 2'd2,
        CLASS_LINE    = 2'd3   // sample sits exactly on the line
    } class_t;

    // done word at the head of every count report
    localparam count_t REPORT_DONE = count_t'(1);

endpackage

/* logic/line_classifier.sv */
/* classifies one sample per cycle against a line, result IQ_CLASS_LATENCY cycles later
   line point and perpendicular must stay static while samples flow */
`timescale 1ns/10ps
`include "iq_analyzer_settings.svh"

module line_classifier import iq_analyzer_pkg::*; (
    input  logic    clk100,
    input  logic    reset,
    input  logic    i_data_valid,   // sample strobe, back to back allowed
    input  sample_t i_i_val,
    input  sample_t i_q_val,
    input  sample_t i_i_line,       // point on the line
    input  sample_t i_q_line,
    input  sample_t i_i_perp,       // normal, points toward excited
    input  sample_t i_q_perp,
    output logic    o_class_valid,
    output class_t  o_class
);

    localparam int DIFF_W = `IQ_SAMPLE_W + 1;     // sample minus line point
    localparam int PROD_W = DIFF_W + `IQ_SAMPLE_W; // full signed product
    localparam int DOT_W  = PROD_W + 1;           // sum of two products

    logic [`IQ_CLASS_LATENCY-1:0] vld_pipe;      // one valid bit per stage
    logic signed [DIFF_W-1:0]     s1_di;
    logic signed [DIFF_W-1:0]     s1_dq;
    logic signed [PROD_W-1:0]     s2_pi;
    logic signed [PROD_W-1:0]     s2_pq;
    logic signed [DOT_W-1:0]      s3_dot;        // dot product, combinational

    // valid bits follow the data through the stages
    always_ff @(posedge clk100) begin
        if (reset) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[`IQ_CLASS_LATENCY-2:0], i_data_valid};
        end
    end

    // stage one forms the vector from the line point to the sample
    always_ff @(posedge clk100) begin
        if (i_data_valid) begin
            s1_di <= i_i_val - i_i_line;  // sign extended, never overflows
            s1_dq <= i_q_val - i_q_line;
        end
    end

    // stage two, one multiplier per axis
    always_ff @(posedge clk100) begin
        if (vld_pipe[0]) begin
            s2_pi <= s1_di * i_i_perp;
            s2_pq <= s1_dq * i_q_perp;
        end
    end

    assign s3_dot = s2_pi + s2_pq;

    // stage three takes the sign of the dot product
    always_ff @(posedge clk100) begin
        if (vld_pipe[`IQ_CLASS_LATENCY-2]) begin
            if (s3_dot == '0) begin
                o_class <= CLASS_LINE;
            end else if (s3_dot[DOT_W-1]) begin
                o_class <= CLASS_GROUND;   // behind the line
            end else begin
                o_class <= CLASS_EXCITED;  // on the side the normal points to
            end
        end
    end

    assign o_class_valid = vld_pipe[`IQ_CLASS_LATENCY-1];

    // every strobed sample comes out as one of the three real classes
    a_no_error_class: assert property (@(posedge clk100) disable iff (reset)
        o_class_valid |-> o_class != CLASS_ERROR);

endmodule

/* logic/run_controller.sv */
/* sequences count-mode runs of i_num_points classifications
   o_report is combinational so the report sees the counts of its own cycle */
`timescale 1ns/10ps

module run_controller import iq_analyzer_pkg::*; (
    input  logic          clk100,
    input  logic          reset,
    input  analyze_mode_t i_mode,
    input  logic          i_stream,
    input  count_t        i_num_points,  // run length, 0 disables counting
    input  count_t        i_points,      // points counted so far
    output logic          o_clear,
    output logic          o_report
);

    typedef enum logic {
        RUN_IDLE,
        RUN_COUNTING
    } run_state_t;

    run_state_t state;
    logic       count_en;  // classify mode, counts wanted

    assign count_en = (i_mode == MODE_CLASSIFY) && !i_stream && (i_num_points != '0);

    always_ff @(posedge clk100) begin
        if (reset) begin
            state <= RUN_IDLE;
        end else begin
            case (state)
                RUN_IDLE:     if (count_en) state <= RUN_COUNTING;
                RUN_COUNTING: if (!count_en) state <= RUN_IDLE;
                default:      state <= RUN_IDLE;
            endcase
        end
    end

    // run is complete as soon as the count reaches its length
    assign o_report = (state == RUN_COUNTING) && (i_points == i_num_points);

    always_comb begin
        if (state == RUN_IDLE) begin
            o_clear = !count_en;   // keep counter empty outside count mode
        end else begin
            o_clear = o_report;    // counter restarts right after the report
        end
    end

    // longer runs need at least two cycles to refill
    a_report_spacing: assert property (@(posedge clk100) disable iff (reset)
        (o_report && i_num_points > count_t'(1)) |=> !o_report);

endmodule

/* verif/iq_analyzer_tb.sv */
/* seeded random testbench for the I/Q analyzer with outputs checked at the falling edge
   expects dump words after 1 cycle, stream codes after 4 and count reports after 5 */
`timescale 1ns/10ps

module iq_analyzer_tb import iq_analyzer_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int N_DUMP     = 200;
    localparam int N_STREAM   = 300;
    localparam int N_COUNT    = 300;  // runs of 7 points
    localparam int N_COUNT1   = 60;   // runs of a single point
    localparam int N_RESERVED = 100;
    localparam int TEST_LEN   = N_DUMP + N_STREAM + N_COUNT + N_COUNT1 + N_RESERVED;

    logic          clk100 = 1'b0;
    logic          reset;
    analyze_mode_t mode;
    logic          stream;
    count_t        num_points;
    logic          data_valid;
    sample_t       i_val, q_val;
    sample_t       i_line, q_line;
    sample_t       i_perp, q_perp;
    logic          dut_valid;
    channel_t      dut_channels;

    int       cyc = 0;          // rising edges seen so far
    int       exp_cyc_q[$];     // cycle at which each expected word is due
    channel_t exp_word_q[$];
    logic     due_now;
    count_t   grp_points, grp_excited, grp_ground, grp_line;  // model run totals

    iq_analyzer i_iq_analyzer (
        .clk100       (clk100),
        .reset        (reset),
        .i_mode       (mode),
        .i_stream     (stream),
        .i_num_points (num_points),
        .i_data_valid (data_valid),
        .i_i_val      (i_val),
        .i_q_val      (q_val),
        .i_i_line     (i_line),
        .i_q_line     (q_line),
        .i_i_perp     (i_perp),
        .i_q_perp     (q_perp),
        .o_valid      (dut_valid),
        .o_channels   (dut_channels)
    );

    always #(CLK_PERIOD / 2) clk100 = ~clk100;

    always @(posedge clk100) cyc <= cyc + 1;

    task automatic check_value(input string what, input channel_t actual,
                               input channel_t expected);
        if (actual !== expected) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    function automatic int rand_span(input int span);  // uniform in -span..span
        return int'($urandom_range(2 * span)) - span;
    endfunction

    // sign of (sample - line point) . perp decides the class
    function automatic class_t expected_class(input sample_t si, input sample_t sq);
        logic signed [127:0] di;
        logic signed [127:0] dq;
        logic signed [127:0] dot;
        di  = si;
        di  = di - i_line;
        dq  = sq;
        dq  = dq - q_line;
        dot = di * i_perp + dq * q_perp;
        if (dot == 0) return CLASS_LINE;
        else if (dot < 0) return CLASS_GROUND;
        else return CLASS_EXCITED;
    endfunction

    task automatic expect_word(input int due, input channel_t word);
        exp_cyc_q.push_back(due);
        exp_word_q.push_back(word);
    endtask

    task automatic model_sample(input int c, input sample_t si, input sample_t sq);
        class_t   cls;
        channel_t word;
        cls = expected_class(si, sq);
        if (mode == MODE_DUMP) begin
            expect_word(c + 1, channel_t'({si, sq}));  // I above Q with the upper half zero
        end else if (mode == MODE_CLASSIFY && stream) begin
            expect_word(c + 4, channel_t'(cls));
        end else if (mode == MODE_CLASSIFY) begin
            grp_points = grp_points + 1'b1;
            case (cls)
                CLASS_EXCITED: grp_excited = grp_excited + 1'b1;
                CLASS_GROUND:  grp_ground  = grp_ground + 1'b1;
                default:       grp_line    = grp_line + 1'b1;
            endcase
            if (grp_points == num_points) begin
                word = channel_t'({count_t'(1), grp_points, grp_excited, grp_ground, grp_line});
                expect_word(c + 5, word);  // strobe, count, report, register
                grp_points  = '0;
                grp_excited = '0;
                grp_ground  = '0;
                grp_line    = '0;
            end
        end
        // reserved modes expect nothing
    endtask

    // new configuration under a 3-cycle reset and a look at the idle outputs
    task automatic start_phase(input analyze_mode_t m, input logic s, input count_t n);
        @(posedge clk100);
        #1;
        reset      = 1'b1;
        data_valid = 1'b0;
        mode       = m;
        stream     = s;
        num_points = n;
        i_line     = sample_t'(rand_span(1 << 20));
        q_line     = sample_t'(rand_span(1 << 20));
        i_perp     = sample_t'(rand_span(1000));
        q_perp     = sample_t'(rand_span(1000));
        if (i_perp == 0) i_perp = 1;  // keep the normal non-zero
        grp_points  = '0;
        grp_excited = '0;
        grp_ground  = '0;
        grp_line    = '0;
        repeat (3) @(posedge clk100);
        #1;
        reset = 1'b0;
        @(negedge clk100);
        check_value("o_valid after reset", channel_t'(dut_valid), '0);
        check_value("o_channels after reset", dut_channels, '0);
    endtask

    task automatic send_samples(input int count);
        int      gap;
        int      t;
        sample_t si;
        sample_t sq;
        for (int k = 0; k < count; k++) begin
            gap = ($urandom_range(1) == 0) ? 0 : int'($urandom_range(3));  // half back to back
            repeat (gap) begin
                @(posedge clk100);
                #1;
                data_valid = 1'b0;
            end
            @(posedge clk100);
            #1;
            if ($urandom_range(7) == 0) begin
                t  = rand_span(200);                  // step along the line direction
                si = i_line - sample_t'(t) * q_perp;
                sq = q_line + sample_t'(t) * i_perp;
            end else begin
                si = sample_t'($urandom);
                sq = sample_t'($urandom);
            end
            data_valid = 1'b1;
            i_val      = si;
            q_val      = sq;
            model_sample(cyc, si, sq);
        end
        @(posedge clk100);
        #1;
        data_valid = 1'b0;
    endtask

    task automatic drain_outputs();
        repeat (8) @(posedge clk100);  // outlasts the 5-cycle report latency
    endtask

    // o_valid must match the model's schedule at every falling edge
    always @(negedge clk100) begin
        due_now = (exp_cyc_q.size() != 0) && (exp_cyc_q[0] == cyc);
        check_value("o_valid", channel_t'(dut_valid), channel_t'(due_now));
        if (due_now) begin
            check_value("o_channels", dut_channels, exp_word_q[0]);
            void'(exp_cyc_q.pop_front());
            void'(exp_word_q.pop_front());
        end
    end

    initial begin
        #(TEST_LEN * 20 * CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(32'ha96fc9ab));
        reset      = 1'b1;
        mode       = MODE_DUMP;
        stream     = 1'b0;
        num_points = '0;
        data_valid = 1'b0;
        i_val      = '0;
        q_val      = '0;
        i_line     = '0;
        q_line     = '0;
        i_perp     = '0;
        q_perp     = '0;

        start_phase(MODE_DUMP, 1'b0, count_t'(0));
        send_samples(N_DUMP);
        drain_outputs();
        start_phase(MODE_CLASSIFY, 1'b1, count_t'(0));
        send_samples(N_STREAM);
        drain_outputs();
        start_phase(MODE_CLASSIFY, 1'b0, count_t'(7));
        send_samples(N_COUNT);
        drain_outputs();
        start_phase(MODE_CLASSIFY, 1'b0, count_t'(1));
        send_samples(N_COUNT1);
        drain_outputs();
        start_phase(analyze_mode_t'(2'd2), 1'b0, count_t'(4));  // reserved mode stays silent
        send_samples(N_RESERVED);
        drain_outputs();

        $display("RESULT: PASS");
        $finish;
    end

endmodule
